//--- all.f
+incdir+sim
common/heapPkg.sv
heap/heapAlu.sv
heap/heapCheckStage.sv
heap/heapElementStage.sv
source/heapTop.sv
sim/heapTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module heapTb -f all.f -Mdir obj_dir -o heapSim
	./obj_dir/heapSim | tee /dev/stderr | grep -x "Test OK" > /dev/null

clean:
	rm -rf obj_dir

//--- sim/heapModel.svh
/* Reference model of the heap, kept as shadow tables inside the testbench.
   Element shadows start unknown, so every element must be written before
   a read of it is checked. Included inside heapTb after its declarations. */
`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

  // ----------------------------------------
  // Shadow tables
  // ----------------------------------------
  logic [arrayBits:0]   shadowHandedOut;               // Arrays ever given out
  logic [arrayBits:0]   shadowFreeTop;                 // Depth of free stack
  logic [arrayBits-1:0] shadowStack [arrayCount];
  logic [arrayCount-1:0] shadowAllocated;
  logic [sizeBits-1:0]  shadowSize [arrayCount];
  logic [dataBits-1:0]  shadowElement [arrayCount][arrayLength];

  function automatic void clearTables();
    shadowHandedOut = '0;
    shadowFreeTop   = '0;
    shadowAllocated = '0;
    for (int a = 0; a < arrayCount; a++) begin
      shadowSize[a] = '0;
    end
  endfunction

  // Error kind for a request against the current shadow state
  function automatic heapErrorE checkError(heapRequestS req);
    logic [sizeBits-1:0] size;
    size = shadowSize[req.array];
    if (req.op == opClear) return errNone;
    if (req.op == opAlloc) begin
      if (shadowFreeTop == '0 && shadowHandedOut == (arrayBits + 1)'(arrayCount))
        return errOutOfMemory;                         // Nothing left to hand out
      return errNone;
    end
    if ({1'b0, req.array} >= shadowHandedOut) return errNotAllocated;
    if (!shadowAllocated[req.array]) return errFreed;
    if ((req.op == opRead || req.op >= opAdd) && {1'b0, req.index} >= size)
      return errOutOfBounds;
    if ((req.op == opPush || req.op == opInc) && size == sizeBits'(arrayLength))
      return errFull;
    if ((req.op == opPop || req.op == opDec) && size == '0) return errEmpty;
    return errNone;
  endfunction

  // New element value for the element operations
  function automatic logic [dataBits-1:0] updatedValue(heapOpE op,
      logic [dataBits-1:0] oldValue, logic [dataBits-1:0] operand);
    case (op)
      opWrite, opPush:        return operand;
      opAdd, opAddAfter:      return oldValue + operand;
      opSubtract, opSubAfter: return oldValue - operand;
      opShiftLeft:            return oldValue << operand[3:0];
      opShiftRight:           return oldValue >> operand[3:0];
      opNotLogical:           return (oldValue == '0) ? 16'd1 : 16'd0;
      opNot:                  return ~oldValue;
      opOr:                   return oldValue | operand;
      opXor:                  return oldValue ^ operand;
      opAnd:                  return oldValue & operand;
      default:                return oldValue;         // Read and Pop keep it
    endcase
  endfunction

  // Applies one request and queues its expected response
  function automatic void modelRequest(heapRequestS req);
    heapResponseS         rsp;
    logic [sizeBits-1:0]  size;
    logic [arrayBits-1:0] number;
    logic [indexBits-1:0] slot;
    logic [dataBits-1:0]  oldValue;
    logic [dataBits-1:0]  newValue;
    logic                 touches;
    rsp.data  = '0;
    rsp.error = checkError(req);
    size      = shadowSize[req.array];
    slot      = req.index;
    touches   = 1'b0;
    if (rsp.error == errNone) begin
      case (req.op)
        opClear: clearTables();
        opAlloc: begin
          if (shadowFreeTop != '0) begin
            shadowFreeTop = shadowFreeTop - 1'b1;      // Last freed comes back first
            number        = shadowStack[shadowFreeTop[arrayBits-1:0]];
          end else begin
            number          = shadowHandedOut[arrayBits-1:0];
            shadowHandedOut = shadowHandedOut + 1'b1;
          end
          shadowAllocated[number] = 1'b1;
          shadowSize[number]      = '0;
          rsp.data                = dataBits'(number);
        end
        opFree: begin
          shadowStack[shadowFreeTop[arrayBits-1:0]] = req.array;
          shadowFreeTop                             = shadowFreeTop + 1'b1;
          shadowAllocated[req.array]                = 1'b0;
        end
        opSize: rsp.data = dataBits'(size);
        opInc:  shadowSize[req.array] = size + 1'b1;
        opDec:  shadowSize[req.array] = size - 1'b1;
        opPush: begin
          slot                  = size[indexBits-1:0]; // Old top
          shadowSize[req.array] = size + 1'b1;
          touches               = 1'b1;
        end
        opPop: begin
          shadowSize[req.array] = size - 1'b1;
          slot                  = shadowSize[req.array][indexBits-1:0];
          touches               = 1'b1;
        end
        opWrite: begin
          if ({1'b0, req.index} >= size) begin
            shadowSize[req.array] = {1'b0, req.index} + 1'b1; // Grow to cover
          end
          touches = 1'b1;
        end
        default: touches = 1'b1;                       // Read and in-place updates
      endcase
      if (touches) begin
        oldValue = shadowElement[req.array][slot];
        newValue = updatedValue(req.op, oldValue, req.operand);
        if (req.op != opRead && req.op != opPop) begin
          shadowElement[req.array][slot] = newValue;
        end
        rsp.data = (req.op inside {opAddAfter, opSubAfter, opRead, opPop}) ? oldValue
                                                                           : newValue;
      end
    end
    expected.push_back(rsp);
  endfunction

`endif

//--- sim/heapTb.sv
/* Testbench for heapTop. Inputs change on the falling edge, the model runs at
   the rising edge where the DUT takes a request, responses are checked on the
   falling edge. Storage is preloaded first so that every read is known. */
`timescale 1ns/1ps
`default_nettype none

module heapTb import heapPkg::*; ();

  localparam int totalRequests = 38 + 15 + 11 + 41 + 209 + 56 + 300; // Per test
  localparam int cycleLimit    = 3 * totalRequests + 50;

  logic         clock;
  logic         resetN;
  logic         reqValid;
  heapRequestS  request;
  logic         rspValid;
  heapResponseS response;

  heapResponseS expected [$];                          // In request order
  heapResponseS want;
  int           seed = 32'hef49_3635;
  int           errorCount;                            // Written by compare only
  int           lostCount;                             // Missing responses
  int           checkCount;
  int           requestCount;
  int           markRequests;
  int           cycleCount;

  `include "heapModel.svh"

  heapTop heapTop_i (
    .clock    (clock),
    .resetN   (resetN),
    .reqValid (reqValid),
    .request  (request),
    .rspValid (rspValid),
    .response (response)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;                        // 100 ns period
  end

  // ----------------------------------------
  // Model and compare processes
  // ----------------------------------------
  initial forever begin
    @(posedge clock);
    if (resetN && reqValid) modelRequest(request);     // Same edge the DUT samples
  end

  initial forever begin
    @(negedge clock);
    if (resetN && rspValid) begin
      if (expected.size() == 0) begin
        $display("A response arrived with no request outstanding");
        errorCount++;
      end else begin
        want = expected.pop_front();
        checkCount++;
        if (response.data !== want.data) begin
          $display("Error: response.data expected %h, actual %h", want.data, response.data);
          errorCount++;
        end
        if (response.error !== want.error) begin
          $display("Error: response.error expected %h, actual %h",
                   want.error, response.error);
          errorCount++;
        end
      end
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout: the run was still going after %0d cycles", cycleLimit);
    $display("Test FAILED");
    $finish;
  end

  // ----------------------------------------
  // Request helpers
  // ----------------------------------------
  task automatic send(input heapOpE op, input int array, input int index,
                      input logic [dataBits-1:0] operand);
    @(negedge clock);
    reqValid        = 1'b1;
    request.op      = op;
    request.array   = arrayBits'(array);
    request.index   = indexBits'(index);
    request.operand = operand;
    requestCount++;
  endtask

  task automatic finishTest(input string name);
    @(negedge clock);
    reqValid = 1'b0;
    repeat (3) @(negedge clock);                       // Two-stage latency plus margin
    @(posedge clock);
    if (expected.size() != 0) begin
      $display("%s: %0d responses never arrived", name, expected.size());
      lostCount++;
    end
    $display("%-12s %4d requests, %0d errors so far", name,
             requestCount - markRequests, errorCount + lostCount);
    markRequests = requestCount;
  endtask

  function automatic logic [dataBits-1:0] fillValue(int a, int i);
    return 16'h5a00 + 16'(a * 32 + i * 3);             // Distinct per array and index
  endfunction

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic preloadStorage();
    send(opClear, 0, 0, '0);
    for (int a = 0; a < arrayCount; a++) send(opAlloc, 0, 0, '0);
    for (int a = 0; a < arrayCount; a++) begin
      for (int i = 0; i < arrayLength; i++) send(opWrite, a, i, fillValue(a, i));
    end
    send(opClear, 0, 0, '0);
    finishTest("Preload");
  endtask

  task automatic allocFreeTest();
    send(opClear, 0, 0, '0);
    repeat (5) send(opAlloc, 0, 0, '0);                // Last one is out of memory
    send(opFree, 1, 0, '0);
    send(opAlloc, 0, 0, '0);                           // Reuses array 1
    send(opFree, 1, 0, '0);
    send(opFree, 1, 0, '0);                            // Double free
    send(opClear, 0, 0, '0);
    for (int a = 0; a < arrayCount; a++) send(opSize, a, 0, '0);
    finishTest("AllocFree");
  endtask

  task automatic writeReadTest();
    send(opClear, 0, 0, '0);
    send(opAlloc, 0, 0, '0);
    send(opWrite, 0, 2, 16'h1234);
    send(opRead, 0, 2, '0);
    send(opSize, 0, 0, '0);
    send(opWrite, 0, 6, 16'hc0de);                     // Past the end
    send(opSize, 0, 0, '0);
    send(opRead, 0, 5, '0);                            // Preloaded value
    send(opRead, 0, 7, '0);                            // Out of bounds
    send(opWrite, 0, 0, 16'h00ff);
    send(opRead, 0, 0, '0);
    finishTest("WriteRead");
  endtask

  task automatic stackTest();
    send(opClear, 0, 0, '0);
    send(opAlloc, 0, 0, '0);
    for (int n = 0; n <= arrayLength; n++) send(opPush, 0, 0, 16'($random(seed)));
    for (int n = 0; n <= arrayLength; n++) send(opPop, 0, 0, '0);
    send(opDec, 0, 0, '0);
    for (int n = 0; n <= arrayLength; n++) send(opInc, 0, 0, '0);
    send(opSize, 0, 0, '0);
    for (int n = 0; n < arrayLength; n++) send(opDec, 0, 0, '0);
    send(opSize, 0, 0, '0);
    send(opDec, 0, 0, '0);
    finishTest("Stack");
  endtask

  task automatic updateTest();
    int     pick;
    int     arrayPick;
    int     indexPick;
    heapOpE op;
    send(opClear, 0, 0, '0);
    for (int a = 0; a < arrayCount; a++) send(opAlloc, 0, 0, '0);
    for (int a = 0; a < arrayCount; a++) send(opWrite, a, 7, 16'($random(seed)));
    arrayPick = 0;
    indexPick = 0;
    for (int n = 0; n < 200; n++) begin
      pick = $unsigned($random(seed)) % 13;
      if ($random(seed) % 3 != 0) begin                // Else same element again
        arrayPick = $unsigned($random(seed)) % 4;
        indexPick = $unsigned($random(seed)) % 8;
      end
      if (pick < 11) begin
        op = heapOpE'(5'(int'(opAdd) + pick));
      end else begin
        op = (pick == 11) ? opRead : opWrite;
      end
      send(op, arrayPick, indexPick, 16'($random(seed)));
    end
    finishTest("Update");
  endtask

  task automatic errorTest();
    send(opClear, 0, 0, '0);
    send(opAlloc, 0, 0, '0);
    send(opAlloc, 0, 0, '0);
    send(opWrite, 0, 3, 16'hbeef);
    send(opWrite, 1, 1, 16'h4321);
    send(opFree, 1, 0, '0);
    for (int k = int'(opFree); k <= int'(opAnd); k++) send(heapOpE'(5'(k)), 1, 0, 16'h1111);
    for (int k = int'(opFree); k <= int'(opAnd); k++) send(heapOpE'(5'(k)), 3, 0, 16'h2222);
    send(opRead, 0, 3, '0);                            // Untouched by the errors
    send(opSize, 0, 0, '0);
    send(opAlloc, 0, 0, '0);                           // Free stack still holds 1
    send(opSize, 1, 0, '0);
    send(opAlloc, 0, 0, '0);                           // Next new numbers are 2 and 3
    send(opAlloc, 0, 0, '0);
    send(opInc, 1, 0, '0);
    send(opInc, 1, 0, '0);
    send(opRead, 1, 0, '0);                            // Not written while freed
    send(opRead, 1, 1, '0);
    send(opInc, 3, 0, '0);
    send(opRead, 3, 0, '0);                            // Not written while unallocated
    finishTest("Errors");
  endtask

  task automatic mixedTest();
    int pick;
    for (int n = 0; n < 300; n++) begin
      pick = $unsigned($random(seed)) % 24;
      if (pick >= 21 || (pick == 0 && $random(seed) % 4 != 0)) begin
        pick = int'(opAlloc);                          // Favour Alloc over Clear
      end
      send(heapOpE'(5'(pick)), $unsigned($random(seed)) % 4,
           $unsigned($random(seed)) % 8, 16'($random(seed)));
    end
    finishTest("Mixed");
  endtask

  initial begin
    resetN       = 1'b0;
    reqValid     = 1'b0;
    request      = '0;
    errorCount   = 0;
    lostCount    = 0;
    checkCount   = 0;
    requestCount = 0;
    markRequests = 0;
    clearTables();
    repeat (8) @(negedge clock);                       // Reset for 8 cycles
    resetN = 1'b1;
    preloadStorage();
    allocFreeTest();
    writeReadTest();
    stackTest();
    updateTest();
    errorTest();
    mixedTest();
    $display("Done: %0d responses checked, %0d wrong values, %0d missing",
             checkCount, errorCount, lostCount);
    if (errorCount == 0 && lostCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/heapTop.sv
/* Heap of fixed-size arrays as a two-stage pipeline. There is no back-pressure.
   A request is taken on every edge with reqValid high and responses return in order. */
`timescale 1ns/1ps
`default_nettype none

module heapTop import heapPkg::*; (
  input  logic         clock,
  input  logic         resetN,                         // Asynchronous, active low
  input  logic         reqValid,
  input  heapRequestS  request,
  output logic         rspValid,
  output heapResponseS response
);

  elementWorkS work;                                   // Between the stages

  // ----------------------------------------
  // Check stage then element stage
  // ----------------------------------------
  heapCheckStage heapCheckStage_i (
    .clock    (clock),
    .resetN   (resetN),
    .reqValid (reqValid),
    .request  (request),
    .work     (work)
  );

  heapElementStage heapElementStage_i (
    .clock    (clock),
    .resetN   (resetN),
    .work     (work),
    .rspValid (rspValid),
    .response (response)
  );

endmodule

`default_nettype wire

//--- heap/heapElementStage.sv
/* Second pipeline stage. Reads the element combinationally from the work item,
   writes the updated value and registers the response at the next edge.
   Element storage has no reset; Clear and Alloc leave old contents in place. */
`timescale 1ns/1ps
`default_nettype none

module heapElementStage import heapPkg::*; (
  input  logic         clock,
  input  logic         resetN,
  input  elementWorkS  work,                           // From check stage
  output logic         rspValid,
  output heapResponseS response
);

  // ----------------------------------------
  // Element storage
  // ----------------------------------------
  logic [dataBits-1:0] storage [arrayCount][arrayLength]; // Arrays by elements

  logic [dataBits-1:0] oldValue;
  logic [dataBits-1:0] newValue;
  logic [dataBits-1:0] returnValue;
  logic                goodItem;                       // Valid and error free
  logic                writeElement;
  logic [dataBits-1:0] rspData;

  assign oldValue = storage[work.array][work.index];   // Sees last edge's write
  assign goodItem = work.valid && work.error == errNone;
  assign writeElement = goodItem && work.touchesElement &&
                        !(work.op inside {opRead, opPop});

  heapAlu heapAlu_i (
    .op          (work.op),
    .oldValue    (oldValue),
    .operand     (work.operand),
    .newValue    (newValue),
    .returnValue (returnValue)
  );

  always_ff @(posedge clock) begin
    if (writeElement) begin
      storage[work.array][work.index] <= newValue;
    end
  end

  // ----------------------------------------
  // Response
  // ----------------------------------------
  always_comb begin
    if (work.error != errNone) begin
      rspData = '0;                                    // Errors carry no data
    end else begin
      case (work.op)
        opAlloc,
        opSize:  rspData = dataBits'(work.tableData);
        opFree,
        opClear,
        opInc,
        opDec:   rspData = '0;
        default: rspData = returnValue;                // Element operations
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= work.valid;                          // One response per item
    end
  end

  always_ff @(posedge clock) begin
    response.data  <= rspData;
    response.error <= work.error;
  end

endmodule

`default_nettype wire

//--- heap/heapCheckStage.sv
/* First pipeline stage. Checks each request against the allocation, free-stack
   and size tables, updates them at the same edge and hands on a work item.
   A second Free of the same array is reported as Freed. */
`timescale 1ns/1ps
`default_nettype none

module heapCheckStage import heapPkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        reqValid,                        // One-cycle strobe
  input  heapRequestS request,
  output elementWorkS work                             // Registered to element stage
);

  // ----------------------------------------
  // Tables
  // ----------------------------------------
  logic [arrayBits:0]   handedOut;                     // Arrays ever given out
  logic [arrayCount-1:0] allocated;                    // Bit per array
  logic [arrayBits-1:0] freeStack [arrayCount];        // Freed array numbers
  logic [arrayBits:0]   freeTop;                       // Entries on free stack
  logic [sizeBits-1:0]  sizes [arrayCount];            // Size per array

  // ----------------------------------------
  // Request decode
  // ----------------------------------------
  logic [sizeBits-1:0]  curSize;
  logic [sizeBits-1:0]  sizeLess;
  logic [sizeBits-1:0]  indexSize;                     // Index widened to size width
  logic [arrayBits:0]   freeTopLess;
  logic [arrayBits-1:0] newArray;                      // Number Alloc would return
  logic                 needsArray;
  logic                 needsBound;
  logic                 touches;
  logic                 accept;                        // Apply table change
  heapErrorE            error;
  logic [indexBits-1:0] elementIndex;
  logic [sizeBits-1:0]  tableData;
  elementWorkS          nextWork;

  assign curSize     = sizes[request.array];
  assign sizeLess    = curSize - 1'b1;
  assign indexSize   = {1'b0, request.index};
  assign freeTopLess = freeTop - 1'b1;
  assign newArray    = (freeTop != '0) ? freeStack[freeTopLess[arrayBits-1:0]]
                                       : handedOut[arrayBits-1:0];

  assign needsArray = !(request.op inside {opClear, opAlloc});
  assign needsBound = request.op inside {opRead, [opAdd:opAnd]};
  assign touches    = request.op inside {opWrite, opRead, opPush, opPop, [opAdd:opAnd]};

  always_comb begin
    error        = errNone;
    elementIndex = request.index;
    tableData    = '0;
    if (needsArray) begin
      if ({1'b0, request.array} >= handedOut) begin
        error = errNotAllocated;
      end else if (!allocated[request.array]) begin
        error = errFreed;
      end else if (needsBound && indexSize >= curSize) begin
        error = errOutOfBounds;
      end else if (request.op inside {opPush, opInc} &&
                   curSize == sizeBits'(arrayLength)) begin
        error = errFull;
      end else if (request.op inside {opPop, opDec} && curSize == '0) begin
        error = errEmpty;
      end
    end
    case (request.op)
      opAlloc: begin
        if (freeTop == '0 && handedOut == (arrayBits + 1)'(arrayCount)) begin
          error = errOutOfMemory;                      // Stack empty, all handed out
        end
        tableData = sizeBits'(newArray);
      end
      opSize:  tableData = curSize;
      opPush:  elementIndex = curSize[indexBits-1:0];  // Old top
      opPop:   elementIndex = sizeLess[indexBits-1:0]; // New top
      default: ;
    endcase
  end

  assign accept = reqValid && error == errNone;

  always_comb begin
    nextWork.valid          = reqValid;
    nextWork.op             = request.op;
    nextWork.array          = request.array;
    nextWork.index          = elementIndex;
    nextWork.operand        = request.operand;
    nextWork.error          = error;
    nextWork.touchesElement = touches;
    nextWork.tableData      = tableData;
  end

  // ----------------------------------------
  // Table and work registers
  // ----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      handedOut  <= '0;
      allocated  <= '0;
      freeTop    <= '0;
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
      work.valid <= 1'b0;
    end else begin
      work <= nextWork;                                // Hand on every cycle
      if (accept) begin
        case (request.op)
          opClear: begin
            handedOut <= '0;                           // Everything unallocated
            allocated <= '0;
            freeTop   <= '0;
            for (int i = 0; i < arrayCount; i++) begin
              sizes[i] <= '0;
            end
          end
          opAlloc: begin
            if (freeTop != '0) begin
              freeTop <= freeTopLess;                  // Reuse a freed array
            end else begin
              handedOut <= handedOut + 1'b1;
            end
            allocated[newArray] <= 1'b1;
            sizes[newArray]     <= '0;                 // Starts empty
          end
          opFree: begin
            freeTop                  <= freeTop + 1'b1;
            allocated[request.array] <= 1'b0;
          end
          opWrite: begin
            if (indexSize >= curSize) begin
              sizes[request.array] <= indexSize + 1'b1; // Grow to cover index
            end
          end
          opPush,
          opInc:   sizes[request.array] <= curSize + 1'b1;
          opPop,
          opDec:   sizes[request.array] <= sizeLess;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept && request.op == opFree) begin
      freeStack[freeTop[arrayBits-1:0]] <= request.array; // Push on free stack
    end
  end

endmodule

`default_nettype wire

//--- heap/heapAlu.sv
/* Element arithmetic for one element, purely combinational.
   Shifts use only the operand's low four bits. */
`timescale 1ns/1ps
`default_nettype none

module heapAlu import heapPkg::*; (
  input  heapOpE              op,
  input  logic [dataBits-1:0] oldValue,                // Current element
  input  logic [dataBits-1:0] operand,
  output logic [dataBits-1:0] newValue,                // Value to store
  output logic [dataBits-1:0] returnValue              // Value to respond with
);

  logic [3:0] shiftAmount;

  assign shiftAmount = operand[3:0];                   // Up to 15 places

  // ----------------------------------------
  // New element value
  // ----------------------------------------
  always_comb begin
    case (op)
      opWrite,
      opPush:       newValue = operand;                // Plain store
      opAdd,
      opAddAfter:   newValue = oldValue + operand;
      opSubtract,
      opSubAfter:   newValue = oldValue - operand;
      opShiftLeft:  newValue = oldValue << shiftAmount;
      opShiftRight: newValue = oldValue >> shiftAmount; // Logical shift
      opNotLogical: newValue = dataBits'(oldValue == '0);
      opNot:        newValue = ~oldValue;
      opOr:         newValue = oldValue | operand;
      opXor:        newValue = oldValue ^ operand;
      opAnd:        newValue = oldValue & operand;
      default:      newValue = oldValue;               // Read, Pop, table ops
    endcase
  end

  // ----------------------------------------
  // Returned value
  // ----------------------------------------
  always_comb begin
    case (op)
      opAddAfter,
      opSubAfter,
      opRead,
      opPop:   returnValue = oldValue;                 // Value before update
      default: returnValue = newValue;
    endcase
  end

endmodule

`default_nettype wire

//--- common/heapPkg.sv
/* Shared widths, operation codes, error kinds and the structs that cross ports.
   The stages decode Add through And as one range, so those codes stay in order. */
`default_nettype none

package heapPkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int arrayBits   = 2;                      // Array number width
  localparam int arrayCount  = 2 ** arrayBits;         // 4 arrays
  localparam int indexBits   = 3;                      // Element index width
  localparam int arrayLength = 8;                      // Elements per array
  localparam int dataBits    = 16;                     // Element width
  localparam int sizeBits    = indexBits + 1;          // Size runs 0..arrayLength

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic [4:0] {
    opClear, opAlloc, opFree,                          // Table only
    opWrite, opRead, opSize,
    opInc, opDec,                                      // Size change
    opPush, opPop,
    opAdd, opAddAfter, opSubtract, opSubAfter,         // Arithmetic updates
    opShiftLeft, opShiftRight,
    opNotLogical, opNot,
    opOr, opXor, opAnd                                 // Bitwise updates
  } heapOpE;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                   // Never handed out
    errFreed,                                          // Currently on free stack
    errOutOfBounds,                                    // Index not below size
    errFull,                                           // Push or Inc at length
    errEmpty,                                          // Pop or Dec at zero
    errOutOfMemory                                     // Alloc with none left
  } heapErrorE;

  // ----------------------------------------
  // Port structs
  // ----------------------------------------
  typedef struct packed {
    heapOpE                op;
    logic [arrayBits-1:0]  array;
    logic [indexBits-1:0]  index;
    logic [dataBits-1:0]   operand;
  } heapRequestS;                                      // 26 bits

  typedef struct packed {
    logic [dataBits-1:0]   data;
    heapErrorE             error;
  } heapResponseS;                                     // 19 bits

  typedef struct packed {
    logic                  valid;
    heapOpE                op;
    logic [arrayBits-1:0]  array;
    logic [indexBits-1:0]  index;                      // Resolved element index
    logic [dataBits-1:0]   operand;
    heapErrorE             error;
    logic                  touchesElement;             // Reads or writes storage
    logic [sizeBits-1:0]   tableData;                  // Alloc number or size
  } elementWorkS;

endpackage

`default_nettype wire
